// ==== project.f ====
+incdir+.
cache_pkg.sv
cache_opctr.sv
icache.sv
dcache.sv
l2cache.sv
l1_l2cache.sv
tb_l1_l2cache.sv

// ==== Makefile ====
# Verilator build for the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_l2cache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_l1_l2cache.sv ====
// cache subsystem testbench
`timescale 1ns/10ps
`include "cache_params.svh"

module tb_l1_l2cache;
    import cache_pkg::*;

    localparam int window_words = 1024;  // 4 KB
    localparam int insn_words   = 128;   // fetch-only region at the bottom
    localparam int line_words   = 1 << `L1_OFFSET_WIDTH;
    localparam int l2_words     = 1 << `L2_OFFSET_WIDTH;
    localparam int l2_lines     = 1 << `L2_INDEX_WIDTH;
    localparam int n_loads      = 8;
    localparam int n_stores     = 16;
    localparam int n_fetches    = 16;
    localparam int n_random     = 200;
    localparam int miss_cost    = 20;  // L1 miss plus dirty L2 victim
    localparam int op_count     = 2 * n_loads + 3 * n_stores + n_fetches + 7 + n_random
                                  + l2_lines;
    localparam int cycle_limit  = 40 * miss_cost * op_count;

    logic             clk = 1'b0;
    logic             reset_i;
    logic             fetch_valid_i;
    addr_t            fetch_addr_i;
    logic             flush_i;
    logic             fetch_valid_o;
    word_t [1:0]      fetch_data_o;
    addr_t            fetch_pc_o;
    logic             fetch_second_o;
    logic             icache_stall_o;
    logic             dreq_valid_i;
    l1_req_t          dreq_i;
    logic             dready_o;
    logic             dresp_valid_o;
    word_t            drdata_o;
    cache_op_t        op_i_i;
    cache_op_t        op_d_i;
    cache_op_t        op_l2_i;
    logic [2:0]       op_busy_o;
    logic             mem_req_o;
    mem_req_t         mem_req_data_o;
    logic             mem_data_ok_i = 1'b0;
    l2_line_t         mem_rdata_i = '0;

    integer seed = 46722;
    int     cycle_cnt = 0;
    string  test_name = "reset";
    int     d_w = 0;      // word of the load in flight
    logic   d_check = 1'b0;
    int     f_exp_w = 0;  // word of the fetch in flight

    word_t init_words [window_words];
    word_t mem_arr [window_words];
    word_t shadow [window_words];
    int    delay_tab [256];
    logic [7:0] delay_ptr;
    logic       mem_busy;
    int         mem_wait;
    logic [9:0] line_base;

    always #50 clk = ~clk;

    l1_l2cache dut0 (
        .clk(clk), .reset_i(reset_i),
        .fetch_valid_i(fetch_valid_i), .fetch_addr_i(fetch_addr_i), .flush_i(flush_i),
        .fetch_valid_o(fetch_valid_o), .fetch_data_o(fetch_data_o),
        .fetch_pc_o(fetch_pc_o), .fetch_second_o(fetch_second_o),
        .icache_stall_o(icache_stall_o),
        .dreq_valid_i(dreq_valid_i), .dreq_i(dreq_i), .dready_o(dready_o),
        .dresp_valid_o(dresp_valid_o), .drdata_o(drdata_o),
        .op_i_i(op_i_i), .op_d_i(op_d_i), .op_l2_i(op_l2_i), .op_busy_o(op_busy_o),
        .mem_req_o(mem_req_o), .mem_req_data_o(mem_req_data_o),
        .mem_data_ok_i(mem_data_ok_i), .mem_rdata_i(mem_rdata_i)
    );

    // words 0..511 at 0x0000, 512..1023 at 0x1000, both halves alias in the L2
    function automatic addr_t word_addr(int w);
        return {19'd0, w[9], 1'b0, w[8:0], 2'b00};
    endfunction

    function automatic word_t byte_merge(word_t old_w, word_t new_w, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // expected contents of a word after all stores so far
    function automatic word_t ref_word(int w);
        return shadow[w];
    endfunction

    function int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function int data_word();
        return insn_words + rand_below(window_words - insn_words);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic access_data(input int w, input logic wr, input word_t wdata,
                               input strb_t strb, input logic want_hit);
        int gap;
        @(posedge clk);
        dreq_valid_i <= 1'b1;
        dreq_i <= '{addr: word_addr(w), wdata: wdata, wstrb: strb, wr: wr};
        d_w = w;
        d_check = !wr;
        @(negedge clk);
        while (!dready_o) @(negedge clk);
        @(posedge clk);  // accepted here
        dreq_valid_i <= 1'b0;
        if (wr) shadow[w] = byte_merge(shadow[w], wdata, strb);
        gap = 0;
        @(negedge clk);
        while (!dresp_valid_o) begin
            gap++;
            @(negedge clk);
        end
        if (want_hit) check_value({test_name, " hit latency"}, 32'd0, 32'(gap));
    endtask

    task automatic fetch_insn(input int w);
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_addr_i <= word_addr(w);
        f_exp_w = w;
        @(negedge clk);
        while (icache_stall_o) @(negedge clk);
        @(posedge clk);
        fetch_valid_i <= 1'b0;
        @(negedge clk);
        while (!fetch_valid_o) @(negedge clk);
    endtask

    task automatic issue_op(input int slot, input addr_t addr);
        cache_op_t op;
        op = '{valid: 1'b1, addr: addr};
        @(posedge clk);
        if (slot == 0) op_i_i <= op;
        else op_l2_i <= op;
        @(posedge clk);
        op_i_i <= '0;
        op_l2_i <= '0;
        @(negedge clk);
        if (!op_busy_o[slot]) fail_run("cache op was not held in its slot");
        while (op_busy_o[slot]) @(negedge clk);
    endtask

    // memory model, one line per request
    assign line_base = {mem_req_data_o.addr[12], mem_req_data_o.addr[10:5], 3'b000};

    always @(posedge clk) begin
        if (reset_i) begin
            mem_data_ok_i <= 1'b0;
            mem_busy <= 1'b0;
            mem_wait <= 0;
            delay_ptr <= 8'd0;
            for (int i = 0; i < window_words; i++) mem_arr[i] = init_words[i];
        end else begin
            mem_data_ok_i <= 1'b0;
            if (mem_busy && mem_wait != 0) begin
                mem_wait <= mem_wait - 1;
            end else if (mem_busy) begin
                mem_busy <= 1'b0;
                mem_data_ok_i <= 1'b1;
                if (mem_req_data_o.addr[31:13] != 19'd0 || mem_req_data_o.addr[11]) begin
                    fail_run("memory request outside the 4 KB test window");
                end
                for (int k = 0; k < l2_words; k++) begin
                    if (mem_req_data_o.wr) begin
                        mem_arr[line_base + 10'(k)] = mem_req_data_o.wdata[32*k +: 32];
                    end else begin
                        mem_rdata_i[32*k +: 32] <= mem_arr[line_base + 10'(k)];
                    end
                end
            end else if (mem_req_o && !mem_data_ok_i) begin
                mem_busy <= 1'b1;
                mem_wait <= delay_tab[delay_ptr];
                delay_ptr <= delay_ptr + 8'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles in %s", cycle_cnt, test_name));
        end
    end

    // response checker
    always @(negedge clk) begin
        if (!reset_i && dresp_valid_o && d_check) begin
            check_value({test_name, " load"}, ref_word(d_w), drdata_o);
        end
        if (!reset_i && fetch_valid_o) begin
            check_value({test_name, " fetch pc"}, word_addr(f_exp_w), fetch_pc_o);
            check_value({test_name, " fetch low word"}, ref_word(f_exp_w), fetch_data_o[0]);
            check_value({test_name, " fetch second"},
                        32'(f_exp_w % line_words != line_words - 1), 32'(fetch_second_o));
            if (f_exp_w % line_words != line_words - 1) begin
                check_value({test_name, " fetch high word"}, ref_word(f_exp_w + 1),
                            fetch_data_o[1]);
            end
        end
    end

    initial begin
        int w;
        int kind;
        int stored_q [$];
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_addr_i = '0;
        flush_i = 1'b0;
        dreq_valid_i = 1'b0;
        dreq_i = '0;
        op_i_i = '0;
        op_d_i = '0;
        op_l2_i = '0;
        for (int i = 0; i < window_words; i++) begin
            init_words[i] = word_t'($random(seed));
            shadow[i] = init_words[i];
        end
        for (int i = 0; i < 256; i++) delay_tab[i] = 1 + rand_below(5);
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        test_name = "loads";
        repeat (n_loads) begin
            w = data_word();
            access_data(w, 1'b0, 32'd0, 4'd0, 1'b0);
            access_data(w, 1'b0, 32'd0, 4'd0, 1'b1);
        end

        test_name = "strobed stores";
        repeat (n_stores) begin
            w = data_word();
            if (rand_below(2) == 1) access_data(w ^ 1, 1'b0, 32'd0, 4'd0, 1'b0);  // line held
            access_data(w, 1'b1, word_t'($random(seed)), strb_t'(rand_below(16)), 1'b0);
            access_data(w, 1'b0, 32'd0, 4'd0, 1'b0);
            stored_q.push_back(w);
        end

        test_name = "fetches";
        fetch_insn(3);
        fetch_insn(4);
        repeat (n_fetches) fetch_insn(rand_below(insn_words));

        test_name = "icache invalidate";
        fetch_insn(5);
        access_data(5, 1'b1, word_t'($random(seed)), 4'hf, 1'b0);
        issue_op(0, word_addr(5));
        fetch_insn(5);
        fetch_insn(4);

        test_name = "random mix";
        repeat (n_random) begin
            kind = rand_below(3);
            if (kind == 0) begin
                fetch_insn(rand_below(insn_words));
            end else if (kind == 1) begin
                if (stored_q.size() > 0 && rand_below(2) == 1) begin
                    w = stored_q[rand_below(stored_q.size())];
                end else begin
                    w = data_word();
                end
                access_data(w, 1'b0, 32'd0, 4'd0, 1'b0);
            end else begin
                w = data_word();
                access_data(w, 1'b1, word_t'($random(seed)), strb_t'(rand_below(16)), 1'b0);
                stored_q.push_back(w);
            end
        end

        test_name = "write-back sweep";
        for (int i = 0; i < l2_lines; i++) begin
            issue_op(2, addr_t'(i * 4 * l2_words));
        end
        for (int i = 0; i < window_words; i++) begin
            check_value($sformatf("%s word %0d", test_name, i), shadow[i], mem_arr[i]);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== l1_l2cache.sv ====
// two-level cache subsystem top
`timescale 1ns/10ps
`include "cache_params.svh"

module l1_l2cache #(
    parameter int i_index_width  = `I_INDEX_WIDTH,
    parameter int d_index_width  = `D_INDEX_WIDTH,
    parameter int l2_index_width = `L2_INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset_i,
    // fetch side
    input  logic                   fetch_valid_i,
    input  cache_pkg::addr_t       fetch_addr_i,
    input  logic                   flush_i,
    output logic                   fetch_valid_o,
    output cache_pkg::word_t [1:0] fetch_data_o,
    output cache_pkg::addr_t       fetch_pc_o,
    output logic                   fetch_second_o,
    output logic                   icache_stall_o,
    // load/store side
    input  logic                   dreq_valid_i,
    input  cache_pkg::l1_req_t     dreq_i,
    output logic                   dready_o,
    output logic                   dresp_valid_o,
    output cache_pkg::word_t       drdata_o,
    // cache ops
    input  cache_pkg::cache_op_t   op_i_i,
    input  cache_pkg::cache_op_t   op_d_i,
    input  cache_pkg::cache_op_t   op_l2_i,
    output logic [2:0]             op_busy_o,
    // memory port
    output logic                   mem_req_o,
    output cache_pkg::mem_req_t    mem_req_data_o,
    input  logic                   mem_data_ok_i,
    input  cache_pkg::l2_line_t    mem_rdata_i
);
    import cache_pkg::*;

    cache_op_t pend_i;
    cache_op_t pend_d;
    cache_op_t pend_l2;
    logic      ack_i;
    logic      ack_d;
    logic      ack_l2;
    logic      ireq;
    addr_t     iaddr;
    logic      idata_ok;
    l1_line_t  iline;
    logic      dreq;
    l1_req_t   dreq_data;
    logic      ddata_ok;
    l1_line_t  dline;

    cache_opctr cache_opctr (
        .clk(clk), .reset_i(reset_i),
        .op_i_i(op_i_i), .op_d_i(op_d_i), .op_l2_i(op_l2_i),
        .ack_i_i(ack_i), .ack_d_i(ack_d), .ack_l2_i(ack_l2),
        .pend_i_o(pend_i), .pend_d_o(pend_d), .pend_l2_o(pend_l2),
        .op_busy_o(op_busy_o)
    );

    icache #(.index_width(i_index_width)) icache (
        .clk(clk), .reset_i(reset_i),
        .fetch_valid_i(fetch_valid_i), .fetch_addr_i(fetch_addr_i), .flush_i(flush_i),
        .fetch_valid_o(fetch_valid_o), .fetch_data_o(fetch_data_o),
        .fetch_pc_o(fetch_pc_o), .fetch_second_o(fetch_second_o),
        .icache_stall_o(icache_stall_o),
        .op_i(pend_i), .op_ack_o(ack_i),
        .l2_req_o(ireq), .l2_addr_o(iaddr), .l2_data_ok_i(idata_ok), .l2_line_i(iline)
    );

    dcache #(.index_width(d_index_width)) dcache (
        .clk(clk), .reset_i(reset_i),
        .dreq_valid_i(dreq_valid_i), .dreq_i(dreq_i), .dready_o(dready_o),
        .dresp_valid_o(dresp_valid_o), .drdata_o(drdata_o),
        .op_i(pend_d), .op_ack_o(ack_d),
        .l2_req_o(dreq), .l2_req_data_o(dreq_data),
        .l2_data_ok_i(ddata_ok), .l2_line_i(dline)
    );

    l2cache #(.index_width(l2_index_width)) l2cache (
        .clk(clk), .reset_i(reset_i),
        .ireq_i(ireq), .iaddr_i(iaddr), .idata_ok_o(idata_ok), .iline_o(iline),
        .dreq_i(dreq), .dreq_data_i(dreq_data), .ddata_ok_o(ddata_ok), .dline_o(dline),
        .op_i(pend_l2), .op_ack_o(ack_l2),
        .mem_req_o(mem_req_o), .mem_req_data_o(mem_req_data_o),
        .mem_data_ok_i(mem_data_ok_i), .mem_rdata_i(mem_rdata_i)
    );

endmodule

// ==== l2cache.sv ====
// shared write-back L2 cache
`timescale 1ns/10ps
`include "cache_params.svh"

module l2cache #(
    parameter int index_width = `L2_INDEX_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 ireq_i,
    input  cache_pkg::addr_t     iaddr_i,
    output logic                 idata_ok_o,
    output cache_pkg::l1_line_t  iline_o,
    input  logic                 dreq_i,
    input  cache_pkg::l1_req_t   dreq_data_i,
    output logic                 ddata_ok_o,
    output cache_pkg::l1_line_t  dline_o,
    input  cache_pkg::cache_op_t op_i,
    output logic                 op_ack_o,
    output logic                 mem_req_o,
    output cache_pkg::mem_req_t  mem_req_data_o,
    input  logic                 mem_data_ok_i,
    input  cache_pkg::l2_line_t  mem_rdata_i
);
    import cache_pkg::*;

    localparam int idx_lsb   = 2 + `L2_OFFSET_WIDTH;
    localparam int tag_width = 32 - idx_lsb - index_width;
    localparam int lines     = 1 << index_width;
    localparam int sel_width = `L2_OFFSET_WIDTH - `L1_OFFSET_WIDTH;
    localparam int l1_bits   = 32 << `L1_OFFSET_WIDTH;

    l2_state_e state;
    l1_req_t   req;     // latched winner
    logic      from_d;
    logic      is_op;   // write-back-invalidate, not an access

    logic [tag_width-1:0] tag_mem [lines];
    l2_line_t             data_mem [lines];
    logic [lines-1:0]     valid_mem;
    logic [lines-1:0]     dirty_mem;

    logic [index_width-1:0]      idx;
    logic [`L2_OFFSET_WIDTH-1:0] woff;
    logic [sel_width-1:0]        sel;
    logic                        hit;
    l2_line_t                    line;
    l1_line_t                    l1_slice;

    assign idx = req.addr[idx_lsb +: index_width];
    assign woff = req.addr[2 +: `L2_OFFSET_WIDTH];
    assign sel = req.addr[2 + `L1_OFFSET_WIDTH +: sel_width];
    assign line = data_mem[idx];
    assign l1_slice = line[l1_bits*sel +: l1_bits];
    assign hit = valid_mem[idx] && (tag_mem[idx] == req.addr[31 -: tag_width]);

    // responses last the single respond cycle
    assign idata_ok_o = (state == l2_respond) && !is_op && !from_d;
    assign ddata_ok_o = (state == l2_respond) && !is_op && from_d;
    assign op_ack_o = (state == l2_respond) && is_op;
    assign iline_o = l1_slice;
    assign dline_o = l1_slice;
    assign mem_req_o = (state == l2_writeback) || (state == l2_fill);

    always_comb begin
        mem_req_data_o.wdata = line;
        mem_req_data_o.wr = (state == l2_writeback);
        if (state == l2_writeback) begin  // victim address
            mem_req_data_o.addr = {tag_mem[idx], idx, {idx_lsb{1'b0}}};
        end else begin
            mem_req_data_o.addr = {req.addr[31:idx_lsb], {idx_lsb{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= l2_idle;
            valid_mem <= '0;
            dirty_mem <= '0;
        end else begin
            case (state)
                l2_idle: if (dreq_i || ireq_i || op_i.valid) state <= l2_lookup;
                l2_lookup: begin
                    if (hit && !is_op) state <= l2_respond;
                    else if (valid_mem[idx] && dirty_mem[idx]) state <= l2_writeback;
                    else if (is_op) state <= l2_respond;
                    else state <= l2_fill;
                end
                l2_writeback: begin
                    if (mem_data_ok_i) begin
                        dirty_mem[idx] <= 1'b0;
                        state <= is_op ? l2_respond : l2_fill;
                    end
                end
                l2_fill: begin
                    if (mem_data_ok_i) begin
                        valid_mem[idx] <= 1'b1;
                        state <= l2_respond;
                    end
                end
                l2_respond: begin
                    if (is_op) valid_mem[idx] <= 1'b0;
                    else if (req.wr) dirty_mem[idx] <= 1'b1;
                    state <= l2_idle;
                end
                default: state <= l2_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == l2_idle) begin  // dcache first, ops only when no request
            from_d <= dreq_i;
            is_op <= !dreq_i && !ireq_i;
            if (dreq_i) req <= dreq_data_i;
            else if (ireq_i) req <= '{addr: iaddr_i, default: '0};
            else req <= '{addr: op_i.addr, default: '0};
        end
        if (state == l2_fill && mem_data_ok_i) begin
            tag_mem[idx] <= req.addr[31 -: tag_width];
            data_mem[idx] <= mem_rdata_i;
        end
        if (state == l2_respond && !is_op && req.wr) begin
            data_mem[idx][32*woff +: 32] <= merge_word(line[32*woff +: 32], req.wdata,
                                                       req.wstrb);
        end
    end

endmodule

// ==== dcache.sv ====
// write-through data L1 cache
`timescale 1ns/10ps
`include "cache_params.svh"

module dcache #(
    parameter int index_width = `D_INDEX_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 dreq_valid_i,
    input  cache_pkg::l1_req_t   dreq_i,
    output logic                 dready_o,
    output logic                 dresp_valid_o,
    output cache_pkg::word_t     drdata_o,
    input  cache_pkg::cache_op_t op_i,
    output logic                 op_ack_o,
    output logic                 l2_req_o,
    output cache_pkg::l1_req_t   l2_req_data_o,
    input  logic                 l2_data_ok_i,
    input  cache_pkg::l1_line_t  l2_line_i
);
    import cache_pkg::*;

    localparam int idx_lsb   = 2 + `L1_OFFSET_WIDTH;
    localparam int tag_width = 32 - idx_lsb - index_width;
    localparam int lines     = 1 << index_width;

    l1_state_e state;
    l1_req_t   req;  // accepted request, held toward L2

    logic [tag_width-1:0] tag_mem [lines];
    l1_line_t             data_mem [lines];
    logic [lines-1:0]     valid_mem;

    logic                        accept;
    logic                        hit;
    l1_req_t                     cur;
    l1_line_t                    cur_line;
    word_t                       cur_word;
    logic [index_width-1:0]      cur_idx;
    logic [`L1_OFFSET_WIDTH-1:0] woff;

    assign dready_o = (state == l1_idle);
    assign accept = dreq_valid_i && dready_o;
    assign l2_req_o = !dready_o;
    assign l2_req_data_o = req;

    assign cur = dready_o ? dreq_i : req;
    assign cur_idx = cur.addr[idx_lsb +: index_width];
    assign woff = cur.addr[2 +: `L1_OFFSET_WIDTH];
    assign cur_line = (state == l1_refill) ? l2_line_i : data_mem[cur_idx];
    assign cur_word = cur_line[32*woff +: 32];
    assign hit = valid_mem[cur_idx] && (tag_mem[cur_idx] == cur.addr[31 -: tag_width]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= l1_idle;
            valid_mem <= '0;
            dresp_valid_o <= 1'b0;
            op_ack_o <= 1'b0;
        end else begin
            dresp_valid_o <= 1'b0;
            op_ack_o <= 1'b0;
            case (state)
                l1_idle: begin
                    if (op_i.valid && !op_ack_o) begin
                        valid_mem[op_i.addr[idx_lsb +: index_width]] <= 1'b0;
                        op_ack_o <= 1'b1;
                    end
                    if (accept) begin
                        if (dreq_i.wr) state <= l1_wait_wr;
                        else if (hit) dresp_valid_o <= 1'b1;
                        else state <= l1_refill;
                    end
                end
                l1_refill: begin
                    if (l2_data_ok_i) begin
                        valid_mem[cur_idx] <= 1'b1;
                        dresp_valid_o <= 1'b1;
                        state <= l1_idle;
                    end
                end
                l1_wait_wr: begin
                    if (l2_data_ok_i) begin  // L2 has the store
                        dresp_valid_o <= 1'b1;
                        state <= l1_idle;
                    end
                end
                default: state <= l1_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req <= dreq_i;
        // no write allocate, only a hitting line takes the store
        if (accept && dreq_i.wr && hit) begin
            data_mem[cur_idx][32*woff +: 32] <= merge_word(cur_word, dreq_i.wdata,
                                                           dreq_i.wstrb);
        end
        if (state == l1_refill && l2_data_ok_i) begin
            tag_mem[cur_idx] <= req.addr[31 -: tag_width];
            data_mem[cur_idx] <= l2_line_i;
        end
        drdata_o <= cur_word;
    end

endmodule

// ==== icache.sv ====
// instruction L1 cache
`timescale 1ns/10ps
`include "cache_params.svh"

module icache #(
    parameter int index_width = `I_INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   fetch_valid_i,
    input  cache_pkg::addr_t       fetch_addr_i,
    input  logic                   flush_i,
    output logic                   fetch_valid_o,
    output cache_pkg::word_t [1:0] fetch_data_o,  // [0] is the word at fetch_pc_o
    output cache_pkg::addr_t       fetch_pc_o,
    output logic                   fetch_second_o,
    output logic                   icache_stall_o,
    input  cache_pkg::cache_op_t   op_i,
    output logic                   op_ack_o,
    output logic                   l2_req_o,
    output cache_pkg::addr_t       l2_addr_o,
    input  logic                   l2_data_ok_i,
    input  cache_pkg::l1_line_t    l2_line_i
);
    import cache_pkg::*;

    localparam int idx_lsb   = 2 + `L1_OFFSET_WIDTH;
    localparam int tag_width = 32 - idx_lsb - index_width;
    localparam int lines     = 1 << index_width;

    l1_state_e state;
    addr_t     req_addr;
    logic      drop;  // flushed during refill

    logic [tag_width-1:0] tag_mem [lines];
    l1_line_t             data_mem [lines];
    logic [lines-1:0]     valid_mem;

    logic                        refilling;
    logic                        accept;
    logic                        hit;
    addr_t                       cur_addr;
    l1_line_t                    cur_line;
    logic [index_width-1:0]      cur_idx;
    logic [`L1_OFFSET_WIDTH-1:0] woff;
    logic [`L1_OFFSET_WIDTH-1:0] woff_next;

    assign refilling = (state == l1_refill);
    assign icache_stall_o = refilling;
    assign accept = fetch_valid_i && !refilling;
    assign l2_req_o = refilling;
    assign l2_addr_o = {req_addr[31:idx_lsb], {idx_lsb{1'b0}}};

    // returned line bypasses the array on refill
    assign cur_addr = refilling ? req_addr : fetch_addr_i;
    assign cur_idx = cur_addr[idx_lsb +: index_width];
    assign cur_line = refilling ? l2_line_i : data_mem[cur_idx];
    assign hit = valid_mem[cur_idx] && (tag_mem[cur_idx] == cur_addr[31 -: tag_width]);
    assign woff = cur_addr[2 +: `L1_OFFSET_WIDTH];
    assign woff_next = woff + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= l1_idle;
            valid_mem <= '0;
            fetch_valid_o <= 1'b0;
            op_ack_o <= 1'b0;
            drop <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            op_ack_o <= 1'b0;
            case (state)
                l1_idle: begin
                    if (op_i.valid && !op_ack_o) begin  // index invalidate
                        valid_mem[op_i.addr[idx_lsb +: index_width]] <= 1'b0;
                        op_ack_o <= 1'b1;
                    end
                    if (accept && hit) begin
                        fetch_valid_o <= !flush_i;
                    end else if (accept) begin
                        state <= l1_refill;
                        drop <= flush_i;
                    end
                end
                l1_refill: begin
                    if (flush_i) drop <= 1'b1;
                    if (l2_data_ok_i) begin
                        valid_mem[cur_idx] <= 1'b1;
                        fetch_valid_o <= !drop && !flush_i;
                        state <= l1_idle;
                    end
                end
                default: state <= l1_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_addr <= fetch_addr_i;
        if (refilling && l2_data_ok_i) begin
            tag_mem[cur_idx] <= req_addr[31 -: tag_width];
            data_mem[cur_idx] <= l2_line_i;
        end
        fetch_pc_o <= cur_addr;
        fetch_data_o <= {cur_line[32*woff_next +: 32], cur_line[32*woff +: 32]};
        fetch_second_o <= (woff != '1);  // next word still in this line
    end

endmodule

// ==== cache_opctr.sv ====
// cache op holding registers
`timescale 1ns/10ps

module cache_opctr (
    input  logic                 clk,
    input  logic                 reset_i,
    input  cache_pkg::cache_op_t op_i_i,
    input  cache_pkg::cache_op_t op_d_i,
    input  cache_pkg::cache_op_t op_l2_i,
    input  logic                 ack_i_i,
    input  logic                 ack_d_i,
    input  logic                 ack_l2_i,
    output cache_pkg::cache_op_t pend_i_o,
    output cache_pkg::cache_op_t pend_d_o,
    output cache_pkg::cache_op_t pend_l2_o,
    output logic [2:0]           op_busy_o
);
    import cache_pkg::*;

    cache_op_t  op_in [3];  // slot 0 icache, 1 dcache, 2 L2
    cache_op_t  pend [3];
    logic [2:0] ack;

    assign op_in[0] = op_i_i;
    assign op_in[1] = op_d_i;
    assign op_in[2] = op_l2_i;
    assign ack = {ack_l2_i, ack_d_i, ack_i_i};
    assign pend_i_o = pend[0];
    assign pend_d_o = pend[1];
    assign pend_l2_o = pend[2];

    for (genvar k = 0; k < 3; k++) begin : g_slot
        always_ff @(posedge clk) begin
            if (reset_i) begin
                pend[k].valid <= 1'b0;
            end else if (ack[k]) begin
                pend[k].valid <= 1'b0;
            end else if (!pend[k].valid && op_in[k].valid) begin
                pend[k] <= op_in[k];  // busy slot drops new ops
            end
        end
        assign op_busy_o[k] = pend[k].valid;
    end

endmodule

// ==== cache_pkg.sv ====
// cache subsystem types
`include "cache_params.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [(32 << `L1_OFFSET_WIDTH)-1:0] l1_line_t;
    typedef logic [(32 << `L2_OFFSET_WIDTH)-1:0] l2_line_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  wr;
    } l1_req_t;

    typedef struct packed {
        addr_t    addr;
        l2_line_t wdata;
        logic     wr;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } cache_op_t;

    typedef enum logic [1:0] {l1_idle, l1_refill, l1_wait_wr} l1_state_e;
    typedef enum logic [2:0] {
        l2_idle, l2_lookup, l2_writeback, l2_fill, l2_respond
    } l2_state_e;

    // byte-strobe merge, shared by dcache and L2
    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

// ==== cache_params.svh ====
// cache geometry
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word offset bits inside a line
`define L1_OFFSET_WIDTH 2
`define L2_OFFSET_WIDTH 3

// index bits per cache
`define I_INDEX_WIDTH   6
`define D_INDEX_WIDTH   6
`define L2_INDEX_WIDTH  7

`endif
